//--- design/scan_out_pkg.sv
`default_nettype none

package scan_out_pkg;

    parameter int COMP_W = 8;
    parameter int DUTY_W = 4;

    // Expansion port use
    typedef enum logic [1:0] {
        EXP_SEL_OFF,
        EXP_SEL_EXTRA_OUT,
        EXP_SEL_LEGACY_IN,
        EXP_SEL_UVC_BDG
    } exp_sel_e;

    // Analog output sync formats
    typedef enum logic [1:0] {
        EXTRA_OUT_RGBHV,
        EXTRA_OUT_RGBCS,
        EXTRA_OUT_RGSB,
        EXTRA_OUT_YPBPR
    } extra_out_e;

    typedef enum logic [1:0] {
        OSD_SEL_BLACK,
        OSD_SEL_BLUE,
        OSD_SEL_YELLOW,
        OSD_SEL_WHITE
    } osd_color_e;

    // One video sample
    typedef struct packed {
        logic [COMP_W-1:0] r;
        logic [COMP_W-1:0] g;
        logic [COMP_W-1:0] b;
        logic              hs;
        logic              vs;
        logic              de;
    } pixel_t;

    typedef struct packed {
        logic [1:0]        spare;
        exp_sel_e          exp_sel;
        extra_out_e        extra_out_mode;
        logic [DUTY_W-1:0] led_duty;
        logic [DUTY_W-1:0] fan_duty;
        logic              framelock;
        logic              poweron;
    } ctrl_word_t;

    // DAC pins on the expansion port
    typedef struct packed {
        logic [COMP_W-1:0] r;
        logic [COMP_W-1:0] g;
        logic [COMP_W-1:0] b;
        logic              hs;
        logic              vs;
        logic              blank_n;
        logic              sync_n;
    } vga_pins_t;

    // OSD colors, r g b
    localparam logic [3*COMP_W-1:0] OSD_BLACK  = 24'h000000;
    localparam logic [3*COMP_W-1:0] OSD_BLUE   = 24'h0000ff;
    localparam logic [3*COMP_W-1:0] OSD_YELLOW = 24'hffff00;
    localparam logic [3*COMP_W-1:0] OSD_WHITE  = 24'hffffff;

    // BT.601 weights in 1/256 units
    localparam int CSC_COEF_W = 10;
    localparam logic signed [CSC_COEF_W-1:0] CSC_Y_R  = 10'sd77;
    localparam logic signed [CSC_COEF_W-1:0] CSC_Y_G  = 10'sd150;
    localparam logic signed [CSC_COEF_W-1:0] CSC_Y_B  = 10'sd29;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PB_R = -10'sd43;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PB_G = -10'sd85;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PB_B = 10'sd128;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PR_R = 10'sd128;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PR_G = -10'sd107;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PR_B = -10'sd21;
    localparam int CSC_OFFSET = 128;

endpackage

`default_nettype wire

//--- design/osd_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module osd_mixer (
    input  wire                          pclk_out,
    input  wire                          po_reset_n,
    input  wire scan_out_pkg::pixel_t     pixel_i,
    input  wire                          osd_enable_i,
    input  wire scan_out_pkg::osd_color_e osd_color_i,
    output scan_out_pkg::pixel_t          mixed_px_o,
    output scan_out_pkg::pixel_t          hdmi_o
);

    import scan_out_pkg::*;

    logic [3*COMP_W-1:0] osd_rgb;
    pixel_t mix_d;
    pixel_t mix_q;
    pixel_t launch_q;

    always_comb begin
        case (osd_color_i)
            OSD_SEL_BLACK:  osd_rgb = OSD_BLACK;
            OSD_SEL_BLUE:   osd_rgb = OSD_BLUE;
            OSD_SEL_YELLOW: osd_rgb = OSD_YELLOW;
            default:        osd_rgb = OSD_WHITE;
        endcase
    end

    // Sync levels always pass, only colors are replaced
    always_comb begin
        mix_d = pixel_i;
        if (osd_enable_i) begin
            {mix_d.r, mix_d.g, mix_d.b} = osd_rgb;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            mix_q    <= '0;
            launch_q <= '0;
        end else begin
            mix_q    <= mix_d;
            // Transmitter launch register
            launch_q <= mix_q;
        end
    end

    assign mixed_px_o = mix_q;
    assign hdmi_o     = launch_q;

    a_osd_color_known: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        osd_enable_i |-> !$isunknown(osd_color_i)
    ) else $error("OSD color unknown while overlay active");

endmodule

`default_nettype wire

//--- design/ypbpr_csc.sv
`timescale 1ns/1ns
`default_nettype none

module ypbpr_csc (
    input  wire                      pclk_out,
    input  wire                      po_reset_n,
    input  wire                      enable_i,
    input  wire scan_out_pkg::pixel_t px_i,
    output scan_out_pkg::pixel_t      px_o
);

    import scan_out_pkg::*;

    localparam int SUM_W = COMP_W + CSC_COEF_W + 2;

    logic signed [SUM_W-1:0] sum_y_q;
    logic signed [SUM_W-1:0] sum_pb_q;
    logic signed [SUM_W-1:0] sum_pr_q;
    logic   en_q;
    pixel_t px_q;
    pixel_t out_d;
    pixel_t out_q;

    function automatic logic signed [SUM_W-1:0] wsum(
        input pixel_t                         p,
        input logic signed [CSC_COEF_W-1:0] kr,
        input logic signed [CSC_COEF_W-1:0] kg,
        input logic signed [CSC_COEF_W-1:0] kb
    );
        wsum = $signed({1'b0, p.r}) * kr + $signed({1'b0, p.g}) * kg
             + $signed({1'b0, p.b}) * kb;
    endfunction

    // Drop fraction, recenter chroma, saturate to component range
    function automatic logic [COMP_W-1:0] clamp_comp(
        input logic signed [SUM_W-1:0] sum,
        input logic                    add_offset
    );
        int off;
        logic signed [SUM_W-1:0] v;
        off = add_offset ? CSC_OFFSET : 0;
        v = (sum >>> 8) + SUM_W'(off);
        if (v < 0) begin
            clamp_comp = '0;
        end else if (v > ((1 << COMP_W) - 1)) begin
            clamp_comp = '1;
        end else begin
            clamp_comp = v[COMP_W-1:0];
        end
    endfunction

    // Weighted sums, only loaded while converting
    always_ff @(posedge pclk_out) begin
        if (enable_i) begin
            sum_y_q  <= wsum(px_i, CSC_Y_R, CSC_Y_G, CSC_Y_B);
            sum_pb_q <= wsum(px_i, CSC_PB_R, CSC_PB_G, CSC_PB_B);
            sum_pr_q <= wsum(px_i, CSC_PR_R, CSC_PR_G, CSC_PR_B);
        end
    end

    always_comb begin
        out_d = px_q;
        if (en_q) begin
            out_d.g = clamp_comp(sum_y_q, 1'b0);
            out_d.b = clamp_comp(sum_pb_q, 1'b1);
            out_d.r = clamp_comp(sum_pr_q, 1'b1);
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            en_q  <= 1'b0;
            px_q  <= '0;
            out_q <= '0;
        end else begin
            en_q  <= enable_i;
            px_q  <= px_i;
            out_q <= out_d;
        end
    end

    assign px_o = out_q;

endmodule

`default_nettype wire

//--- design/vga_dac_fmt.sv
`timescale 1ns/1ns
`default_nettype none

module vga_dac_fmt (
    input  wire                          pclk_out,
    input  wire                          po_reset_n,
    input  wire scan_out_pkg::exp_sel_e   exp_sel_i,
    input  wire scan_out_pkg::extra_out_e mode_i,
    input  wire scan_out_pkg::pixel_t     px_i,
    output scan_out_pkg::vga_pins_t       vga_o,
    output logic                         vga_oe_o
);

    import scan_out_pkg::*;

    logic      load;
    logic      csync;
    logic      sep_sync;
    logic      sync_on_green;
    vga_pins_t pre_d;
    vga_pins_t pre_q;
    vga_pins_t out_q;

    assign load          = (exp_sel_i == EXP_SEL_EXTRA_OUT);
    assign csync         = ~(px_i.hs ^ px_i.vs);
    assign sep_sync      = (mode_i == EXTRA_OUT_RGBHV);
    assign sync_on_green = (mode_i == EXTRA_OUT_RGSB) || (mode_i == EXTRA_OUT_YPBPR);

    always_comb begin
        pre_d.r  = px_i.r;
        pre_d.g  = px_i.g;
        pre_d.b  = px_i.b;
        // Composite sync rides on hs outside RGBHV
        pre_d.hs = sep_sync ? px_i.hs : csync;
        pre_d.vs = sep_sync ? px_i.vs : 1'b1;
        // Component video carries blanking in the levels
        pre_d.blank_n = (mode_i == EXTRA_OUT_YPBPR) ? 1'b1 : px_i.de;
        pre_d.sync_n  = sync_on_green ? csync : 1'b0;
    end

    // Both stages freeze while the port is not an output
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pre_q <= '0;
            out_q <= '0;
        end else if (load) begin
            pre_q <= pre_d;
            out_q <= pre_q;
        end
    end

    assign vga_o    = out_q;
    assign vga_oe_o = load;

    a_ypbpr_unblanked: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        (load && mode_i == EXTRA_OUT_YPBPR) ##1 load |=> vga_o.blank_n
    ) else $error("YPbPr output blanked");

endmodule

`default_nettype wire

//--- design/status_indicators.sv
`timescale 1ns/1ns
`default_nettype none

module status_indicators #(
    parameter int PWM_PERIOD = 1024,
    parameter int LED_HOLD_W = 24
) (
    input  wire                          pclk_out,
    input  wire                          po_reset_n,
    input  wire scan_out_pkg::ctrl_word_t ctrl_i,
    input  wire                          resync_strobe_i,
    output logic [1:0]                   led_o,
    output logic                         fan_pwm_n_o
);

    import scan_out_pkg::*;

    localparam int CNT_W = $clog2(PWM_PERIOD);
    localparam int STEP  = PWM_PERIOD / 16;

    logic [CNT_W-1:0]      pwm_cnt;
    logic                  fan_ch;
    logic                  led_ch;
    logic                  strobe_sync1_q;
    logic                  strobe_sync2_q;
    logic                  strobe_prev_q;
    logic                  strobe_rise;
    logic [LED_HOLD_W-1:0] hold_q;
    logic [1:0]            led_d;
    logic                  fan_n_d;

    function automatic logic pwm_high(
        input logic [CNT_W-1:0]  cnt,
        input logic [DUTY_W-1:0] duty
    );
        pwm_high = (int'(cnt) < int'(duty) * STEP);
    endfunction

    // Shared free-running period counter
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pwm_cnt <= '0;
        end else if (pwm_cnt == CNT_W'(PWM_PERIOD - 1)) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    assign fan_ch = pwm_high(pwm_cnt, ctrl_i.fan_duty);
    assign led_ch = pwm_high(pwm_cnt, ctrl_i.led_duty);

    // Strobe arrives from another domain
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_sync1_q <= 1'b0;
            strobe_sync2_q <= 1'b0;
            strobe_prev_q  <= 1'b0;
        end else begin
            strobe_sync1_q <= resync_strobe_i;
            strobe_sync2_q <= strobe_sync1_q;
            strobe_prev_q  <= strobe_sync2_q;
        end
    end

    assign strobe_rise = strobe_sync2_q & ~strobe_prev_q;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hold_q <= '0;
        end else if (ctrl_i.poweron) begin
            if (strobe_rise) begin
                hold_q <= '1;
            end else if (hold_q != '0) begin
                hold_q <= hold_q - 1'b1;
            end
        end else begin
            // Standby blink from the MSB
            hold_q <= hold_q - 1'b1;
        end
    end

    assign led_d = {2{led_ch}} & (ctrl_i.poweron ? {ctrl_i.framelock, |hold_q}
                                                 : {1'b0, ~hold_q[LED_HOLD_W-1]});
    assign fan_n_d = ~(ctrl_i.poweron & fan_ch);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            led_o       <= '0;
            fan_pwm_n_o <= 1'b1;
        end else begin
            led_o       <= led_d;
            fan_pwm_n_o <= fan_n_d;
        end
    end

    a_pwm_cnt_range: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        int'(pwm_cnt) < PWM_PERIOD
    ) else $error("PWM counter out of range");

endmodule

`default_nettype wire

//--- design/scan_out_top.sv
`timescale 1ns/1ns
`default_nettype none

module scan_out_top #(
    parameter int PWM_PERIOD = 1024,
    parameter int LED_HOLD_W = 24
) (
    input  wire                          pclk_out,
    input  wire                          po_reset_n,
    input  wire scan_out_pkg::pixel_t     pixel_i,
    input  wire                          osd_enable_i,
    input  wire scan_out_pkg::osd_color_e osd_color_i,
    input  wire scan_out_pkg::ctrl_word_t ctrl_i,
    input  wire                          resync_strobe_i,
    output scan_out_pkg::pixel_t          hdmi_o,
    output scan_out_pkg::vga_pins_t       vga_o,
    output logic                         vga_oe_o,
    output logic                         psave_n_o,
    output logic [1:0]                   led_o,
    output logic                         fan_pwm_n_o
);

    import scan_out_pkg::*;

    pixel_t mixed_px;
    pixel_t csc_px;
    logic   csc_en;

    // Conversion only for component output on the expansion port
    assign csc_en = (ctrl_i.exp_sel == EXP_SEL_EXTRA_OUT)
                 && (ctrl_i.extra_out_mode == EXTRA_OUT_YPBPR);

    assign psave_n_o = ctrl_i.poweron;

    osd_mixer u_osd_mixer (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .pixel_i      (pixel_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .mixed_px_o   (mixed_px),
        .hdmi_o       (hdmi_o)
    );

    ypbpr_csc u_ypbpr_csc (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .enable_i   (csc_en),
        .px_i       (mixed_px),
        .px_o       (csc_px)
    );

    vga_dac_fmt u_vga_dac_fmt (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .exp_sel_i  (ctrl_i.exp_sel),
        .mode_i     (ctrl_i.extra_out_mode),
        .px_i       (csc_px),
        .vga_o      (vga_o),
        .vga_oe_o   (vga_oe_o)
    );

    status_indicators #(
        .PWM_PERIOD (PWM_PERIOD),
        .LED_HOLD_W (LED_HOLD_W)
    ) u_status_indicators (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .ctrl_i          (ctrl_i),
        .resync_strobe_i (resync_strobe_i),
        .led_o           (led_o),
        .fan_pwm_n_o     (fan_pwm_n_o)
    );

endmodule

`default_nettype wire

//--- verification/scan_out_ref.svh
`ifndef SCAN_OUT_REF_SVH
`define SCAN_OUT_REF_SVH

// Overlay colors by select code, r g b
function automatic pixel_t osd_mix(input pixel_t p, input logic en, input logic [1:0] sel);
    pixel_t m;
    m = p;
    if (en) begin
        case (sel)
            2'd0:    {m.r, m.g, m.b} = 24'h000000;
            2'd1:    {m.r, m.g, m.b} = 24'h0000ff;
            2'd2:    {m.r, m.g, m.b} = 24'hffff00;
            default: {m.r, m.g, m.b} = 24'hffffff;
        endcase
    end
    return m;
endfunction

function automatic logic [7:0] saturate8(input int v);
    if (v < 0) return 8'h00;
    if (v > 255) return 8'hff;
    return v[7:0];
endfunction

// Weights in 1/256 units, floor division by 256
function automatic pixel_t to_ypbpr(input pixel_t p);
    int r;
    int g;
    int b;
    pixel_t q;
    r = int'(p.r);
    g = int'(p.g);
    b = int'(p.b);
    q = p;
    q.g = saturate8((77 * r + 150 * g + 29 * b) >>> 8);
    q.b = saturate8(((-43 * r - 85 * g + 128 * b) >>> 8) + 128);
    q.r = saturate8(((128 * r - 107 * g - 21 * b) >>> 8) + 128);
    return q;
endfunction

function automatic vga_pins_t vga_format(input pixel_t p, input extra_out_e mode);
    vga_pins_t v;
    logic csync;
    csync = ~(p.hs ^ p.vs);
    v.r = p.r;
    v.g = p.g;
    v.b = p.b;
    v.hs = (mode == EXTRA_OUT_RGBHV) ? p.hs : csync;
    v.vs = (mode == EXTRA_OUT_RGBHV) ? p.vs : 1'b1;
    v.blank_n = (mode == EXTRA_OUT_YPBPR) ? 1'b1 : p.de;
    v.sync_n = (mode == EXTRA_OUT_RGSB || mode == EXTRA_OUT_YPBPR) ? csync : 1'b0;
    return v;
endfunction

// Fan is active low, so low cycles equal the high time of the channel
function automatic int fan_low_cycles(input logic on, input int duty, input int period);
    if (!on) return 0;
    return duty * (period / 16);
endfunction

`endif

//--- verification/scan_out_tb.sv
`timescale 1ns/1ns
`default_nettype none

module scan_out_tb;

    import scan_out_pkg::*;

    localparam int PWM_PERIOD  = 64;
    localparam int LED_HOLD_W  = 8;
    localparam int DRAIN_LIMIT = 50;

    logic        pclk_out;
    logic        po_reset_n;
    pixel_t      pixel_i;
    logic        osd_enable_i;
    osd_color_e  osd_color_i;
    ctrl_word_t  ctrl;
    logic        resync_strobe_i;
    pixel_t      hdmi_o;
    vga_pins_t   vga_o;
    logic        vga_oe_o;
    logic        psave_n_o;
    logic [1:0]  led_o;
    logic        fan_pwm_n_o;

    int          cyc = 0;
    int          errors = 0;
    int          cmp_errors = 0;
    int          timeouts = 0;
    logic [31:0] rng = 32'd60227;
    int          hdmi_due_q[$];
    pixel_t      hdmi_exp_q[$];
    int          vga_due_q[$];
    vga_pins_t   vga_exp_q[$];
    vga_pins_t   vga_last_exp = '0;

    `include "scan_out_ref.svh"

    scan_out_top #(
        .PWM_PERIOD (PWM_PERIOD),
        .LED_HOLD_W (LED_HOLD_W)
    ) dut0 (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .pixel_i         (pixel_i),
        .osd_enable_i    (osd_enable_i),
        .osd_color_i     (osd_color_i),
        .ctrl_i          (ctrl),
        .resync_strobe_i (resync_strobe_i),
        .hdmi_o          (hdmi_o),
        .vga_o           (vga_o),
        .vga_oe_o        (vga_oe_o),
        .psave_n_o       (psave_n_o),
        .led_o           (led_o),
        .fan_pwm_n_o     (fan_pwm_n_o)
    );

    always #50 pclk_out = ~pclk_out;

    always @(posedge pclk_out) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_cycle();
        @(posedge pclk_out);
        #10;
    endtask

    // HDMI is due 2 cycles later and VGA 5 cycles later
    task automatic drive_pixel();
        pixel_t p;
        pixel_t m;
        pixel_t c;
        rng = lcg_next(rng);
        p = pixel_t'(rng[31:5]);
        rng = lcg_next(rng);
        pixel_i = p;
        osd_enable_i = rng[31];
        osd_color_i = osd_color_e'(rng[30:29]);
        m = osd_mix(p, rng[31], rng[30:29]);
        hdmi_due_q.push_back(cyc + 2);
        hdmi_exp_q.push_back(m);
        if (ctrl.exp_sel == EXP_SEL_EXTRA_OUT) begin
            c = (ctrl.extra_out_mode == EXTRA_OUT_YPBPR) ? to_ypbpr(m) : m;
            vga_last_exp = vga_format(c, ctrl.extra_out_mode);
            vga_due_q.push_back(cyc + 5);
            vga_exp_q.push_back(vga_last_exp);
        end
    endtask

    task automatic drain_queues();
        int n;
        n = 0;
        next_cycle();
        while ((hdmi_due_q.size() > 0 || vga_due_q.size() > 0) && n < DRAIN_LIMIT) begin
            next_cycle();
            n++;
        end
        if (hdmi_due_q.size() > 0 || vga_due_q.size() > 0) begin
            timeouts++;
            $display("Timeout: expected pixels still pending after %0d cycles", DRAIN_LIMIT);
            hdmi_due_q.delete();
            hdmi_exp_q.delete();
            vga_due_q.delete();
            vga_exp_q.delete();
        end
    endtask

    task automatic run_video(input extra_out_e mode, input int n);
        ctrl.exp_sel = EXP_SEL_EXTRA_OUT;
        ctrl.extra_out_mode = mode;
        repeat (n) begin
            drive_pixel();
            next_cycle();
        end
        drain_queues();
    endtask

    task automatic check_port_disabled();
        vga_pins_t saved;
        saved = vga_last_exp;
        ctrl.exp_sel = EXP_SEL_LEGACY_IN;
        repeat (20) begin
            drive_pixel();
            @(negedge pclk_out);
            if (vga_oe_o !== 1'b0) begin
                errors++;
                $display("CHECK FAILED vga_oe_o exp=0 got=%h", vga_oe_o);
            end
            if (vga_o !== saved) begin
                errors++;
                $display("CHECK FAILED vga_o exp=%h got=%h", saved, vga_o);
            end
            next_cycle();
        end
        drain_queues();
    endtask

    // Samples start at the strobe drive and the hold loads 3 edges later
    task automatic check_resync_leds();
        bit seen_sync[8];
        bit seen_lock[8];
        int late;
        late = 3 + (1 << LED_HOLD_W) + PWM_PERIOD;
        ctrl.framelock = 1'b1;
        ctrl.led_duty = 4'd15;
        for (int i = 0; i < 8 * PWM_PERIOD; i++) begin
            resync_strobe_i = (i < 3);
            @(negedge pclk_out);
            if (led_o[0]) seen_sync[i / PWM_PERIOD] = 1'b1;
            if (led_o[1]) seen_lock[i / PWM_PERIOD] = 1'b1;
            if (i > late && led_o[0]) begin
                errors++;
                $display("Resync LED still lit %0d cycles after the strobe", i);
            end
            next_cycle();
        end
        for (int w = 0; w < 8; w++) begin
            if (w < (1 << LED_HOLD_W) / PWM_PERIOD && !seen_sync[w]) begin
                errors++;
                $display("Resync LED never lit in PWM period %0d after the strobe", w);
            end
            if (!seen_lock[w]) begin
                errors++;
                $display("Framelock LED never lit in PWM period %0d", w);
            end
        end
    endtask

    task automatic check_leds_dark(input logic lock, input logic [3:0] duty,
                                   input logic [1:0] mask);
        ctrl.framelock = lock;
        ctrl.led_duty = duty;
        for (int i = 0; i < 2 * PWM_PERIOD; i++) begin
            resync_strobe_i = (i < 3);
            @(negedge pclk_out);
            if (i >= 2 && (led_o & mask) != 2'b00) begin
                errors++;
                $display("CHECK FAILED led_o exp=%h got=%h", led_o & ~mask, led_o);
            end
            next_cycle();
        end
    endtask

    task automatic check_fan(input logic on, input logic [3:0] duty);
        int lows;
        int exp_lows;
        lows = 0;
        ctrl.poweron = on;
        ctrl.fan_duty = duty;
        repeat (2) next_cycle();
        repeat (PWM_PERIOD) begin
            @(negedge pclk_out);
            if (!fan_pwm_n_o) lows++;
            next_cycle();
        end
        exp_lows = fan_low_cycles(on, int'(duty), PWM_PERIOD);
        if (lows != exp_lows) begin
            errors++;
            $display("CHECK FAILED fan_pwm_n_o low cycles exp=%h got=%h", exp_lows, lows);
        end
        if (psave_n_o !== on) begin
            errors++;
            $display("CHECK FAILED psave_n_o exp=%h got=%h", on, psave_n_o);
        end
    endtask

    always @(negedge pclk_out) begin
        while (hdmi_due_q.size() > 0 && hdmi_due_q[0] <= cyc) begin
            if (hdmi_due_q[0] == cyc && hdmi_o !== hdmi_exp_q[0]) begin
                cmp_errors++;
                $display("CHECK FAILED hdmi_o exp=%h got=%h", hdmi_exp_q[0], hdmi_o);
            end
            void'(hdmi_due_q.pop_front());
            void'(hdmi_exp_q.pop_front());
        end
        while (vga_due_q.size() > 0 && vga_due_q[0] <= cyc) begin
            if (vga_due_q[0] == cyc && vga_o !== vga_exp_q[0]) begin
                cmp_errors++;
                $display("CHECK FAILED vga_o exp=%h got=%h", vga_exp_q[0], vga_o);
            end
            if (vga_due_q[0] == cyc && vga_oe_o !== 1'b1) begin
                cmp_errors++;
                $display("CHECK FAILED vga_oe_o exp=1 got=%h", vga_oe_o);
            end
            void'(vga_due_q.pop_front());
            void'(vga_exp_q.pop_front());
        end
    end

    initial begin
        pclk_out = 1'b0;
        po_reset_n = 1'b0;
        pixel_i = '0;
        osd_enable_i = 1'b0;
        osd_color_i = OSD_SEL_BLACK;
        resync_strobe_i = 1'b0;
        ctrl = '0;
        ctrl.poweron = 1'b1;
        ctrl.framelock = 1'b1;
        ctrl.led_duty = 4'd15;
        repeat (5) next_cycle();
        if ({hdmi_o, vga_o, led_o, fan_pwm_n_o} !== {55'd0, 2'b00, 1'b1}) begin
            errors++;
            $display("CHECK FAILED reset outputs exp=%h got=%h",
                     {55'd0, 2'b00, 1'b1}, {hdmi_o, vga_o, led_o, fan_pwm_n_o});
        end
        po_reset_n = 1'b1;
        next_cycle();
        run_video(EXTRA_OUT_RGBHV, 100);
        run_video(EXTRA_OUT_RGBCS, 100);
        run_video(EXTRA_OUT_RGSB, 100);
        run_video(EXTRA_OUT_YPBPR, 200);
        check_port_disabled();
        check_resync_leds();
        check_leds_dark(1'b0, 4'd15, 2'b10);
        check_leds_dark(1'b1, 4'd0, 2'b11);
        check_fan(1'b1, 4'd3);
        check_fan(1'b1, 4'd12);
        check_fan(1'b0, 4'd9);
        $display("Run complete: errors=%0d timeouts=%0d", errors + cmp_errors, timeouts);
        if (errors + cmp_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- scan_out_top.f
+incdir+verification
design/scan_out_pkg.sv
design/osd_mixer.sv
design/ypbpr_csc.sv
design/vga_dac_fmt.sv
design/status_indicators.sv
design/scan_out_top.sv
verification/scan_out_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= scan_out_tb
RTL_TOP    ?= scan_out_top
FILELIST   ?= scan_out_top.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= TEST RESULT: FAIL
PASS_MSG   ?= TEST RESULT: PASS
VFLAGS     ?= --timescale 1ns/1ns --timing -Wno-fatal
LINT_FLAGS ?= -Wall --timescale 1ns/1ns

RTL_SRCS = design/scan_out_pkg.sv design/osd_mixer.sv design/ypbpr_csc.sv \
           design/vga_dac_fmt.sv design/status_indicators.sv design/scan_out_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
